/* tb/ifu_tests.txt */
# target count stall_pct ar_delay r_delay mid_read first_word
# hex target, decimal fields, hex expected first instruction word
# the first row runs straight after reset, its target is the reset pc
# mid_read 1 redirects away again while a read is still open
80000000 24  0 0 0 0 93000000
80000104 12  0 1 2 0 93000104
80001008 20 30 0 0 0 93001008
8000200c 16 25 3 5 0 9300200c
80003000 10  0 2 2 1 93003000
80000ffc  9 20 4 1 0 93000ffc
80004010 18 40 0 6 1 93004010
8000123c  8 10 7 0 0 9300123c
80005004 14 15 1 1 1 93005004
80000000 12  0 2 3 0 93000000
80006ff8 11 35 5 5 1 93006ff8
80007020 16  0 0 1 0 93007020

/* sim.f */
+incdir+source
source/ifu_pkg.sv
source/pc_gen.sv
source/fetch_line_buffer.sv
source/inst_out_stage.sv
source/ifu_top.sv
tb/tb_line_mem.sv
tb/tb_ifu.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch unit testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_ifu -f sim.f -o tb_ifu_sim

out=$(./obj_dir/tb_ifu_sim)
echo "$out"

if echo "$out" | grep -q "^SIMULATION PASSED$"; then
  exit 0
fi
exit 1

/* tb/tb_ifu.sv */
module tb_ifu
  import ifu_pkg::*;
();

  logic       clk;
  logic       rst_n;
  logic       stall_i;
  logic       redirect_i;
  addr_t      redirect_pc_i;
  logic       ar_ready_i;
  logic       ar_valid_o;
  addr_t      ar_addr_o;
  logic       r_valid_i;
  line_t      r_data_i;
  resp_t      r_resp_i;
  logic       r_ready_o;
  resp_t      resp_o;
  logic       inst_valid_o;
  fetch_out_s out_o;
  int         ar_dly;
  int         r_dly;

  // one entry per row of the test file
  addr_t tgt_q[$];
  int    cnt_q[$];
  int    stall_q[$];
  int    ard_q[$];
  int    rd_q[$];
  int    mid_q[$];
  inst_t first_q[$];

  addr_t exp_pc;
  inst_t exp_first;
  logic  first_pending = 1'b0;
  logic  stall_prev = 1'b0;
  logic  redirect_prev = 1'b0;
  logic  seq_ar = 1'b0;
  logic  decoy_on = 1'b0;
  addr_t decoy_line;
  int    collected = 0;
  int    checked = 0;
  int    ar_count = 0;
  int    value_errs = 0;
  int    event_errs = 0;
  int    cycles = 0;
  int    cycle_limit = 100000;

  ifu_top ifu_top_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .ar_ready_i    (ar_ready_i),
    .ar_valid_o    (ar_valid_o),
    .ar_addr_o     (ar_addr_o),
    .r_valid_i     (r_valid_i),
    .r_data_i      (r_data_i),
    .r_resp_i      (r_resp_i),
    .r_ready_o     (r_ready_o),
    .resp_o        (resp_o),
    .inst_valid_o  (inst_valid_o),
    .out_o         (out_o)
  );

  tb_line_mem line_mem_inst (
    .clk        (clk),
    .ar_valid_i (ar_valid_o),
    .ar_addr_i  (ar_addr_o),
    .ar_dly_i   (ar_dly),
    .r_dly_i    (r_dly),
    .r_ready_i  (r_ready_o),
    .ar_ready_o (ar_ready_i),
    .r_valid_o  (r_valid_i),
    .r_data_o   (r_data_i),
    .r_resp_o   (r_resp_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic addr_t line_base(input addr_t a);
    return {a[31:4], 4'h0};
  endfunction

  task automatic print_counts;
    $display("errors: %0d wrong values, %0d other failures, %0d instructions checked",
             value_errs, event_errs, checked);
  endtask

  initial begin
    while (cycles <= cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
    print_counts();
    $display("SIMULATION FAILED");
    $finish;
  end

  // ======================================================================
  // checks at the falling edge
  // ======================================================================

  task automatic check_reset_state;
    if (ar_valid_o !== 1'b0) begin
      value_errs++;
      $display("Fail ar_valid_o: got %h, expected 0", ar_valid_o);
    end
    if (r_ready_o !== 1'b0) begin
      value_errs++;
      $display("Fail r_ready_o: got %h, expected 0", r_ready_o);
    end
    if (inst_valid_o !== 1'b0) begin
      value_errs++;
      $display("Fail inst_valid_o: got %h, expected 0", inst_valid_o);
    end
  endtask

  task automatic check_cycle;
    inst_t exp_inst;
    exp_inst = exp_pc ^ 32'h1300_0000;
    if (inst_valid_o === 1'b1) begin
      if (stall_prev) begin
        event_errs++;
        $display("inst_valid_o was high in the cycle after a stall");
      end
      if (redirect_prev) begin
        event_errs++;
        $display("inst_valid_o was high in the cycle after a redirect");
      end
      if (out_o.pc !== exp_pc) begin
        value_errs++;
        $display("Fail out_o.pc: got %h, expected %h", out_o.pc, exp_pc);
      end
      if (out_o.inst !== exp_inst) begin
        value_errs++;
        $display("Fail out_o.inst: got %h, expected %h", out_o.inst, exp_inst);
      end
      if (first_pending && out_o.inst !== exp_first) begin
        value_errs++;
        $display("Fail out_o.inst: got %h, expected %h", out_o.inst, exp_first);
      end
      // data words of the dropped line decode back to its address
      if (decoy_on && line_base(out_o.inst ^ 32'h1300_0000) === decoy_line) begin
        event_errs++;
        $display("an instruction from the discarded line was delivered");
      end
      if (resp_o !== 2'b00) begin
        value_errs++;
        $display("Fail resp_o: got %h, expected 0", resp_o);
      end
      first_pending = 1'b0;
      exp_pc = exp_pc + 32'd4;
      collected++;
      checked++;
    end else if (inst_valid_o !== 1'b0) begin
      value_errs++;
      $display("Fail inst_valid_o: got %h, expected 0", inst_valid_o);
    end
    if (ar_valid_o === 1'b1 && ar_ready_i === 1'b1) begin
      // right after reset each line is asked for once and in order
      if (seq_ar && ar_addr_o !== tgt_q[0] + 32'(ar_count * 16)) begin
        value_errs++;
        $display("Fail ar_addr_o: got %h, expected %h", ar_addr_o,
                 tgt_q[0] + 32'(ar_count * 16));
      end
      ar_count++;
    end
    stall_prev    = stall_i;
    redirect_prev = redirect_i;
    if (redirect_i) begin
      exp_pc = redirect_pc_i;
    end
  endtask

  task automatic next_cycle;
    @(negedge clk);
    check_cycle();
    @(posedge clk);
    #2;
  endtask

  // ======================================================================
  // stimulus
  // ======================================================================

  task automatic redirect_to(input addr_t target);
    stall_i       = 1'b0;
    redirect_i    = 1'b1;
    redirect_pc_i = target;
    next_cycle();
    redirect_i    = 1'b0;
  endtask

  task automatic collect(input int count, input int stall_pct);
    collected = 0;
    while (collected < count) begin
      stall_i    = (int'($urandom % 100) < stall_pct);
      redirect_i = 1'b0;
      next_cycle();
    end
    stall_i = 1'b0;
  endtask

  task automatic read_tests;
    int    fd;
    string text;
    addr_t t;
    inst_t e;
    int    c;
    int    s;
    int    a;
    int    r;
    int    m;
    fd = $fopen("tb/ifu_tests.txt", "r");
    if (fd == 0) begin
      event_errs++;
      $display("could not open tb/ifu_tests.txt");
    end else begin
      while ($fgets(text, fd) != 0) begin
        if ($sscanf(text, "%h %d %d %d %d %d %h", t, c, s, a, r, m, e) == 7) begin
          tgt_q.push_back(t);
          cnt_q.push_back(c);
          stall_q.push_back(s);
          ard_q.push_back(a);
          rd_q.push_back(r);
          mid_q.push_back(m);
          first_q.push_back(e);
        end
      end
      $fclose(fd);
    end
    if (tgt_q.size() == 0) begin
      event_errs++;
      $display("no test vectors were read");
    end
  endtask

  initial begin
    int    v;
    int    lines;
    addr_t decoy;
    void'($urandom(90912));
    rst_n         = 1'b1;
    stall_i       = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    ar_dly        = 0;
    r_dly         = 0;
    read_tests();
    cycle_limit = 200;
    foreach (cnt_q[i]) begin
      cycle_limit += cnt_q[i] * (ard_q[i] + rd_q[i] + 4);
    end

    // reset is active high here
    repeat (7) begin
      @(posedge clk);
      @(negedge clk);
      check_reset_state();
    end
    @(posedge clk);
    #2;
    rst_n = 1'b0;

    for (v = 0; v < tgt_q.size(); v++) begin
      ar_dly = ard_q[v];
      r_dly  = rd_q[v];
      if (v == 0) begin
        exp_pc = tgt_q[0];
        seq_ar = 1'b1;
      end else if (mid_q[v] != 0) begin
        // decoy redirect first and then leave while its read is open
        decoy = tgt_q[v] ^ 32'h0001_0000;
        redirect_to(decoy);
        while (!(ar_valid_o === 1'b1 && ar_addr_o === line_base(decoy))) begin
          next_cycle();
        end
        decoy_line = line_base(decoy);
        decoy_on   = 1'b1;
        redirect_to(tgt_q[v]);
      end else begin
        redirect_to(tgt_q[v]);
      end
      exp_first     = first_q[v];
      first_pending = 1'b1;
      collect(cnt_q[v], stall_q[v]);
      if (v == 0) begin
        // the next line may already be requested
        lines = int'((line_base(exp_pc - 32'd4) - tgt_q[0]) >> 4) + 1;
        if (ar_count < lines || ar_count > lines + 1) begin
          event_errs++;
          $display("%0d line requests seen while crossing %0d lines", ar_count, lines);
        end
        seq_ar = 1'b0;
      end
      decoy_on = 1'b0;
    end

    print_counts();
    if (value_errs == 0 && event_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* tb/tb_line_mem.sv */
module tb_line_mem (
  input  logic         clk,
  input  logic         ar_valid_i,
  input  logic [31:0]  ar_addr_i,
  input  int           ar_dly_i,
  input  int           r_dly_i,
  input  logic         r_ready_i,
  output logic         ar_ready_o,
  output logic         r_valid_o,
  output logic [127:0] r_data_o,
  output logic [1:0]   r_resp_o
);

  logic [31:0] addr;
  int          dly_ar;
  int          dly_r;

  // each word holds its own byte address xor a fixed pattern
  function automatic logic [127:0] make_line(input logic [31:0] base);
    logic [127:0] data;
    int           i;
    data = '0;
    for (i = 0; i < 4; i++) begin
      data[i*32 +: 32] = (base + 32'(4 * i)) ^ 32'h1300_0000;
    end
    return data;
  endfunction

  // drive point of the next cycle
  task automatic step;
    @(posedge clk);
    #2;
  endtask

  // ======================================================================
  // one read at a time, delays taken when the request is first seen
  // ======================================================================

  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    r_resp_o   = 2'b00;
    forever begin
      @(negedge clk);
      if (ar_valid_i === 1'b1) begin
        addr   = ar_addr_i;
        dly_ar = ar_dly_i;
        dly_r  = r_dly_i;
        repeat (dly_ar) step();
        step();
        ar_ready_o = 1'b1;
        // ar_valid is held, so the transfer is on the next edge
        step();
        ar_ready_o = 1'b0;
        repeat (dly_r) step();
        while (r_ready_i !== 1'b1) step();
        r_data_o  = make_line(addr);
        r_resp_o  = 2'b00;
        r_valid_o = 1'b1;
        step();
        r_valid_o = 1'b0;
        r_data_o  = '0;
      end
    end
  end

endmodule

/* source/ifu_top.sv */
module ifu_top
  import ifu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // core side strobes
  input  logic       stall_i,
  input  logic       redirect_i,
  input  addr_t      redirect_pc_i,
  // read address channel
  input  logic       ar_ready_i,
  output logic       ar_valid_o,
  output addr_t      ar_addr_o,
  // read data channel
  input  logic       r_valid_i,
  input  line_t      r_data_i,
  input  resp_t      r_resp_i,
  output logic       r_ready_o,
  // towards the decoder
  output resp_t      resp_o,
  output logic       inst_valid_o,
  output fetch_out_s out_o
);

  fetch_req_s fetch_req;
  line_hit_s  line_hit;

  // ====================================================================
  // stage 1, fetch pc
  // ====================================================================

  pc_gen pc_gen_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .hit_i         (line_hit.hit),
    .req_o         (fetch_req)
  );

  // ====================================================================
  // stage 2, line buffer and read channel
  // ====================================================================

  fetch_line_buffer fetch_line_buffer_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (fetch_req),
    .ar_ready_i (ar_ready_i),
    .ar_valid_o (ar_valid_o),
    .ar_addr_o  (ar_addr_o),
    .r_valid_i  (r_valid_i),
    .r_data_i   (r_data_i),
    .r_resp_i   (r_resp_i),
    .r_ready_o  (r_ready_o),
    .resp_o     (resp_o),
    .hit_o      (line_hit)
  );

  // ====================================================================
  // stage 3, registered instruction
  // ====================================================================

  inst_out_stage inst_out_stage_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall_i      (stall_i),
    .hit_i        (line_hit),
    .inst_valid_o (inst_valid_o),
    .out_o        (out_o)
  );

endmodule

/* source/inst_out_stage.sv */
`include "ifu_settings.svh"

module inst_out_stage
  import ifu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       stall_i,
  input  line_hit_s  hit_i,
  output logic       inst_valid_o,
  output fetch_out_s out_o
);

  // ====================================================================
  // word select
  // ====================================================================

  logic [`IFU_OFFSET_BITS-3:0] word_sel;
  inst_t                       word;
  logic                        take;
  logic                        valid_q;
  fetch_out_s                  out_q;

  // pc bits 3 and 2 pick one of four words
  assign word_sel = hit_i.pc[`IFU_OFFSET_BITS-1:2];
  assign word     = hit_i.line[word_sel*32 +: 32];

  // word is handed on only when the core is not stalled
  assign take = hit_i.hit && !stall_i;

  // ====================================================================
  // output register
  // ====================================================================

  always_ff @(posedge clk) begin
    if (rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_q.pc   <= hit_i.pc;
      out_q.inst <= word;
    end
  end

  assign inst_valid_o = valid_q;
  assign out_o        = out_q;

endmodule

/* source/fetch_line_buffer.sv */
`include "ifu_settings.svh"

module fetch_line_buffer
  import ifu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  fetch_req_s req_i,
  // read address channel
  input  logic       ar_ready_i,
  output logic       ar_valid_o,
  output addr_t      ar_addr_o,
  // read data channel
  input  logic       r_valid_i,
  input  line_t      r_data_i,
  input  resp_t      r_resp_i,
  output logic       r_ready_o,
  // status and lookup result
  output resp_t      resp_o,
  output line_hit_s  hit_o
);

  fetch_state_e state_q;
  fetch_state_e state_d;

  line_t     line_q;
  line_tag_t tag_q;
  logic      valid_q;

  line_tag_t req_tag;
  line_tag_t fetch_tag_q;
  logic      ar_valid_q;
  logic      discard_q;
  resp_t     resp_q;

  logic      miss;
  logic      start_req;
  logic      ar_fire;
  logic      r_fire;
  logic      fill_en;

  // ====================================================================
  // tag compare
  // ====================================================================

  assign req_tag = req_i.pc[31:`IFU_OFFSET_BITS];
  assign miss    = !valid_q || (tag_q != req_tag);

  // a redirect cycle never produces an instruction
  assign hit_o.hit  = !miss && !req_i.redirect;
  assign hit_o.pc   = req_i.pc;
  assign hit_o.line = line_q;

  // ====================================================================
  // read channel fsm
  // ====================================================================

  // raise a request one cycle after the mismatch is seen
  assign start_req = (state_q == FETCH_IDLE) && !ar_valid_q && miss;
  assign ar_fire   = ar_valid_q && ar_ready_i;
  assign r_fire    = r_valid_i && r_ready_o;

  // beat hit by a redirect is dropped, now or earlier in the read
  assign fill_en = r_fire && !discard_q && !req_i.redirect;

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH_IDLE: begin
        if (ar_fire) begin
          state_d = FETCH_WAIT_DATA;
        end
      end
      FETCH_WAIT_DATA: begin
        if (r_fire) begin
          state_d = FETCH_IDLE;
        end
      end
      default: begin
        state_d = FETCH_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= FETCH_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ar valid holds until accepted
  always_ff @(posedge clk) begin
    if (rst_n) begin
      ar_valid_q <= 1'b0;
    end else if (start_req) begin
      ar_valid_q <= 1'b1;
    end else if (ar_fire) begin
      ar_valid_q <= 1'b0;
    end
  end

  // line number of the read in flight, stable until the beat
  always_ff @(posedge clk) begin
    if (start_req) begin
      fetch_tag_q <= req_tag;
    end
  end

  // redirect while a read is pending, the returning line is stale
  always_ff @(posedge clk) begin
    if (rst_n) begin
      discard_q <= 1'b0;
    end else if (r_fire) begin
      discard_q <= 1'b0;
    end else if (req_i.redirect && (ar_valid_q || (state_q == FETCH_WAIT_DATA))) begin
      discard_q <= 1'b1;
    end
  end

  assign ar_valid_o = ar_valid_q;
  assign ar_addr_o  = {fetch_tag_q, {`IFU_OFFSET_BITS{1'b0}}};
  assign r_ready_o  = (state_q == FETCH_WAIT_DATA);

  // ====================================================================
  // line storage
  // ====================================================================

  // old line keeps serving hits until the fill lands
  always_ff @(posedge clk) begin
    if (rst_n) begin
      valid_q <= 1'b0;
      resp_q  <= '0;
    end else if (fill_en) begin
      valid_q <= 1'b1;
      resp_q  <= r_resp_i;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_en) begin
      line_q <= r_data_i;
      tag_q  <= fetch_tag_q;
    end
  end

  assign resp_o = resp_q;

endmodule

/* source/pc_gen.sv */
`include "ifu_settings.svh"

module pc_gen
  import ifu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       stall_i,
  input  logic       redirect_i,
  input  addr_t      redirect_pc_i,
  input  logic       hit_i,
  output fetch_req_s req_o
);

  // ====================================================================
  // fetch pc register
  // ====================================================================

  addr_t pc_q;
  addr_t pc_d;
  logic  advance;

  // step only when the current word was handed to the output stage
  assign advance = hit_i && !stall_i;

  // redirect wins over a normal step
  always_comb begin
    pc_d = pc_q;
    if (redirect_i) begin
      pc_d = redirect_pc_i;
    end else if (advance) begin
      pc_d = pc_q + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      pc_q <= `IFU_RESET_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  // ====================================================================
  // request towards the line buffer
  // ====================================================================

  // on a redirect cycle the target is already presented, so the
  // line buffer can look up the new line without waiting a cycle
  always_comb begin
    req_o.redirect = redirect_i;
    if (redirect_i) begin
      req_o.pc = redirect_pc_i;
    end else begin
      req_o.pc = pc_q;
    end
  end

endmodule

/* source/ifu_pkg.sv */
`include "ifu_settings.svh"

package ifu_pkg;

  // ====================================================================
  // basic types
  // ====================================================================

  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [`IFU_LINE_BITS-1:0] line_t;

  // line number, the address with its offset bits dropped
  typedef logic [32-`IFU_OFFSET_BITS-1:0] line_tag_t;

  // read response code from the r channel
  typedef logic [1:0] resp_t;

  // read channel fsm
  typedef enum logic {
    FETCH_IDLE      = 1'b0,
    FETCH_WAIT_DATA = 1'b1
  } fetch_state_e;

  // ====================================================================
  // stage to stage bundles
  // ====================================================================

  typedef struct packed {
    addr_t pc;
    logic  redirect;
  } fetch_req_s;

  typedef struct packed {
    logic  hit;
    addr_t pc;
    line_t line;
  } line_hit_s;

  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fetch_out_s;

endpackage

/* source/ifu_settings.svh */
`ifndef IFU_SETTINGS_SVH
`define IFU_SETTINGS_SVH

// ======================================================================
// fetch unit constants
// ======================================================================

// first fetch address after reset
`define IFU_RESET_PC 32'h8000_0000

// one cache line, four 32-bit words
`define IFU_LINE_BITS 128

// byte offset inside a line
// word index is bits [IFU_OFFSET_BITS-1:2] of the pc
`define IFU_OFFSET_BITS 4

`endif
